//--- Makefile
TOP := tb_msx_bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir

# The run passes only when the simulation prints the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- flist.f
src/msx_pkg.sv
src/cpu_clock_enable.sv
src/io_decode.sv
src/vdp_port.sv
src/ppi_slot.sv
src/cpu_read_mux.sv
src/msx_bus_top.sv
testbench/msx_bus_assert.sv
testbench/tb_msx_bus.sv

//--- src/cpu_clock_enable.sv
`timescale 1ns/1ns

module cpu_clock_enable (
  input  logic cpuClock,
  input  logic n_hard_reset,
  output logic o_clk_en,
  output logic o_clk_edge
);
  import msx_pkg::*;

  logic [CPU_CNT_W-1:0] clk_count;
  logic                 clk_en_d;   // Enable delayed by one cycle

  // Free running divide by CPU_DIV
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      clk_count <= '0;
      clk_en_d  <= 1'b0;
    end else begin
      clk_en_d <= o_clk_en;
      if (clk_count == CPU_CNT_W'(CPU_DIV - 1)) begin
        clk_count <= '0;
      end else begin
        clk_count <= clk_count + 1'b1;
      end
    end
  end

  // High for counts 4 to 6
  assign o_clk_en = clk_count[CPU_CNT_W-1];

  // One cycle per CPU clock period
  assign o_clk_edge = o_clk_en && !clk_en_d;

endmodule

//--- src/cpu_read_mux.sv
`timescale 1ns/1ns

module cpu_read_mux (
  input  logic              cpuClock,
  input  logic              n_hard_reset,
  input  logic              i_psg_addr_wr,
  input  logic [7:0]        i_data,
  output logic [3:0]        o_psg_addr,
  input  msx_pkg::io_sel_e  i_io_sel,
  input  logic              i_mem_rd,
  input  msx_pkg::mem_src_e i_mem_src,
  input  logic [7:0]        i_port_a,
  input  logic [7:0]        i_port_b,
  input  logic [7:0]        i_port_c,
  input  logic [7:0]        i_vram_data,
  input  logic [7:0]        i_status,
  input  logic [7:0]        i_psg_data,
  input  logic [7:0]        i_ram_data,
  input  logic [7:0]        i_rom_data,
  input  logic [5:0]        i_btn,
  output logic [7:0]        o_cpu_data
);
  import msx_pkg::*;

  logic [7:0] joystick;

  // PSG register select
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      o_psg_addr <= 4'h0;
    end else if (i_psg_addr_wr) begin
      o_psg_addr <= i_data[3:0];
    end
  end

  assign joystick = {2'b00, ~i_btn};   // Buttons are active low

  // ============================================================
  // CPU read data
  // ============================================================
  always_comb begin
    o_cpu_data = 8'hFF;   // Floating bus
    case (i_io_sel)
      IO_VDP_DATA:   o_cpu_data = i_vram_data;
      IO_VDP_STATUS: o_cpu_data = i_status;
      IO_PPI_A:      o_cpu_data = i_port_a;
      IO_PPI_B:      o_cpu_data = i_port_b;
      IO_PPI_C:      o_cpu_data = i_port_c;
      IO_PSG_DATA: begin
        if (o_psg_addr == 4'(PSG_JOY_REG)) begin
          o_cpu_data = joystick;
        end else begin
          o_cpu_data = i_psg_data;
        end
      end
      default: begin
        if (i_mem_rd) begin
          case (i_mem_src)
            MEM_RAM: o_cpu_data = i_ram_data;
            MEM_ROM: o_cpu_data = i_rom_data;
            default: o_cpu_data = 8'h00;   // Empty slot
          endcase
        end
      end
    endcase
  end

endmodule

//--- src/io_decode.sv
`timescale 1ns/1ns

module io_decode (
  input  logic             cpuClock,
  input  logic             n_hard_reset,
  input  logic             i_clk_edge,
  input  logic             i_n_wr,
  input  logic             i_n_rd,
  input  logic             i_n_iorq,
  input  logic             i_n_mreq,
  input  logic [7:0]       i_addr,
  output logic             o_vdp_data_wr,
  output logic             o_vdp_ctrl_wr,
  output logic             o_psg_addr_wr,
  output logic             o_psg_wr,
  output logic             o_ppi_a_wr,
  output logic             o_ppi_c_wr,
  output logic             o_ppi_ctrl_wr,
  output logic             o_vdp_data_rd,
  output logic             o_vdp_ctrl_rd,
  output logic             o_mem_rd,
  output logic             o_mem_wr,
  output msx_pkg::io_sel_e o_io_sel
);
  import msx_pkg::*;

  logic io_wr;
  logic io_rd;
  logic wr_taken;   // Write of this access already issued
  logic wr_go;

  assign io_wr    = !i_n_wr && !i_n_iorq;
  assign io_rd    = !i_n_rd && !i_n_iorq;
  assign o_mem_wr = !i_n_wr && !i_n_mreq;
  assign o_mem_rd = !i_n_rd && !i_n_mreq;

  // At most one write strobe per bus access, even if it spans several edges
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      wr_taken <= 1'b0;
    end else if (!io_wr) begin
      wr_taken <= 1'b0;
    end else if (i_clk_edge) begin
      wr_taken <= 1'b1;
    end
  end

  assign wr_go = i_clk_edge && io_wr && !wr_taken;

  // ============================================================
  // Qualified write strobes
  // ============================================================
  assign o_vdp_data_wr = wr_go && (i_addr == PORT_VDP_DATA);
  assign o_vdp_ctrl_wr = wr_go && (i_addr == PORT_VDP_CTRL);
  assign o_psg_addr_wr = wr_go && (i_addr == PORT_PSG_ADDR);
  assign o_psg_wr      = wr_go && (i_addr == PORT_PSG_WR);
  assign o_ppi_a_wr    = wr_go && (i_addr == PORT_PPI_A);
  assign o_ppi_c_wr    = wr_go && (i_addr == PORT_PPI_C);
  assign o_ppi_ctrl_wr = wr_go && (i_addr == PORT_PPI_CTRL);

  // Read levels held for the whole access
  assign o_vdp_data_rd = io_rd && (i_addr == PORT_VDP_DATA);
  assign o_vdp_ctrl_rd = io_rd && (i_addr == PORT_VDP_CTRL);

  always_comb begin
    o_io_sel = IO_NONE;
    if (io_rd) begin
      case (i_addr)
        PORT_VDP_DATA: o_io_sel = IO_VDP_DATA;
        PORT_VDP_CTRL: o_io_sel = IO_VDP_STATUS;
        PORT_PSG_RD:   o_io_sel = IO_PSG_DATA;
        PORT_PPI_A:    o_io_sel = IO_PPI_A;
        PORT_PPI_B:    o_io_sel = IO_PPI_B;
        PORT_PPI_C:    o_io_sel = IO_PPI_C;
        default:       o_io_sel = IO_NONE;   // Unmapped port
      endcase
    end
  end

endmodule

//--- src/msx_bus_top.sv
`timescale 1ns/1ns

module msx_bus_top (
  input  logic                          cpuClock,
  input  logic                          n_hard_reset,
  input  logic                          i_n_wr,
  input  logic                          i_n_rd,
  input  logic                          i_n_iorq,
  input  logic                          i_n_mreq,
  input  logic [15:0]                   i_addr,
  input  logic [7:0]                    i_cpu_dout,
  input  logic [7:0]                    i_vram_data,
  input  logic                          i_interrupt_flag,
  input  logic                          i_sprite_collision,
  input  logic [7:0]                    i_ram_data,
  input  logic [7:0]                    i_rom_data,
  input  logic [7:0]                    i_port_b,
  input  logic [7:0]                    i_psg_data,
  input  logic [5:0]                    i_btn,
  output logic [7:0]                    o_cpu_data,
  output logic                          o_clk_en,
  output logic                          o_n_int,
  output logic                          o_vram_wr,
  output logic                          o_vram_rd,
  output logic                          o_ram_we,
  output logic                          o_psg_wr,
  output logic [msx_pkg::VRAM_ADDR_W-1:0] o_vram_addr,
  output msx_pkg::screen_mode_e         o_screen_mode,
  output logic [3:0]                    o_psg_addr,
  output logic [3:0]                    o_key_row,
  output logic                          o_click
);
  import msx_pkg::*;

  logic       clk_edge;
  logic       vdp_data_wr;
  logic       vdp_ctrl_wr;
  logic       psg_addr_wr;
  logic       ppi_a_wr;
  logic       ppi_c_wr;
  logic       ppi_ctrl_wr;
  logic       vdp_data_rd;
  logic       vdp_ctrl_rd;
  logic       mem_rd;
  logic       mem_wr;
  io_sel_e    io_sel;
  mem_src_e   mem_src;
  logic [7:0] vdp_status;
  logic [7:0] port_a;
  logic [7:0] port_c;

  // ============================================================
  // Stages
  // ============================================================
  cpu_clock_enable cpu_clock_enable_i (
    .cpuClock     (cpuClock),
    .n_hard_reset (n_hard_reset),
    .o_clk_en     (o_clk_en),
    .o_clk_edge   (clk_edge)
  );

  io_decode io_decode_i (
    .cpuClock      (cpuClock),
    .n_hard_reset  (n_hard_reset),
    .i_clk_edge    (clk_edge),
    .i_n_wr        (i_n_wr),
    .i_n_rd        (i_n_rd),
    .i_n_iorq      (i_n_iorq),
    .i_n_mreq      (i_n_mreq),
    .i_addr        (i_addr[7:0]),   // Z80 I/O uses the low byte
    .o_vdp_data_wr (vdp_data_wr),
    .o_vdp_ctrl_wr (vdp_ctrl_wr),
    .o_psg_addr_wr (psg_addr_wr),
    .o_psg_wr      (o_psg_wr),
    .o_ppi_a_wr    (ppi_a_wr),
    .o_ppi_c_wr    (ppi_c_wr),
    .o_ppi_ctrl_wr (ppi_ctrl_wr),
    .o_vdp_data_rd (vdp_data_rd),
    .o_vdp_ctrl_rd (vdp_ctrl_rd),
    .o_mem_rd      (mem_rd),
    .o_mem_wr      (mem_wr),
    .o_io_sel      (io_sel)
  );

  vdp_port vdp_port_i (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_clk_edge         (clk_edge),
    .i_data_wr          (vdp_data_wr),
    .i_ctrl_wr          (vdp_ctrl_wr),
    .i_data_rd          (vdp_data_rd),
    .i_ctrl_rd          (vdp_ctrl_rd),
    .i_data             (i_cpu_dout),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .o_vram_addr        (o_vram_addr),
    .o_vram_wr          (o_vram_wr),
    .o_vram_rd          (o_vram_rd),
    .o_status           (vdp_status),
    .o_screen_mode      (o_screen_mode),
    .o_n_int            (o_n_int)
  );

  ppi_slot ppi_slot_i (
    .cpuClock     (cpuClock),
    .n_hard_reset (n_hard_reset),
    .i_port_a_wr  (ppi_a_wr),
    .i_port_c_wr  (ppi_c_wr),
    .i_ctrl_wr    (ppi_ctrl_wr),
    .i_data       (i_cpu_dout),
    .i_page       (i_addr[15:14]),
    .i_mem_wr     (mem_wr),
    .o_port_a     (port_a),
    .o_port_c     (port_c),
    .o_ram_we     (o_ram_we),
    .o_mem_src    (mem_src)
  );

  cpu_read_mux cpu_read_mux_i (
    .cpuClock      (cpuClock),
    .n_hard_reset  (n_hard_reset),
    .i_psg_addr_wr (psg_addr_wr),
    .i_data        (i_cpu_dout),
    .o_psg_addr    (o_psg_addr),
    .i_io_sel      (io_sel),
    .i_mem_rd      (mem_rd),
    .i_mem_src     (mem_src),
    .i_port_a      (port_a),
    .i_port_b      (i_port_b),
    .i_port_c      (port_c),
    .i_vram_data   (i_vram_data),
    .i_status      (vdp_status),
    .i_psg_data    (i_psg_data),
    .i_ram_data    (i_ram_data),
    .i_rom_data    (i_rom_data),
    .i_btn         (i_btn),
    .o_cpu_data    (o_cpu_data)
  );

  assign o_key_row = port_c[3:0];   // Keyboard row select
  assign o_click   = port_c[7];

endmodule

//--- src/msx_pkg.sv
package msx_pkg;

  // ============================================================
  // Clock and sizes
  // ============================================================
  localparam int CPU_DIV       = 7;                  // cpuClock / 7 gives 3.5 MHz
  localparam int CPU_CNT_W     = $clog2(CPU_DIV);
  localparam int VDP_REG_COUNT = 8;
  localparam int VDP_REG_IDX_W = $clog2(VDP_REG_COUNT);
  localparam int VRAM_ADDR_W   = 14;                 // 16 KB of VRAM
  localparam int PSG_JOY_REG   = 14;                 // Joystick on PSG port A
  localparam int ROM_SLOT      = 1;                  // Cartridge
  localparam int RAM_SLOT      = 0;

  // ============================================================
  // I/O map
  // ============================================================
  typedef enum logic [7:0] {
    PORT_VDP_DATA = 8'h98,
    PORT_VDP_CTRL = 8'h99,
    PORT_PSG_ADDR = 8'hA0,
    PORT_PSG_WR   = 8'hA1,
    PORT_PSG_RD   = 8'hA2,
    PORT_PPI_A    = 8'hA8,
    PORT_PPI_B    = 8'hA9,
    PORT_PPI_C    = 8'hAA,
    PORT_PPI_CTRL = 8'hAB
  } io_port_e;

  // Source of data for an I/O read
  typedef enum logic [2:0] {
    IO_NONE,
    IO_VDP_DATA,
    IO_VDP_STATUS,
    IO_PSG_DATA,
    IO_PPI_A,
    IO_PPI_B,
    IO_PPI_C
  } io_sel_e;

  typedef enum logic [1:0] {
    MEM_RAM,
    MEM_ROM,
    MEM_NONE
  } mem_src_e;

  // TMS9918 style modes
  typedef enum logic [1:0] {
    MODE_TEXT       = 2'd0,
    MODE_GRAPHIC1   = 2'd1,
    MODE_GRAPHIC2   = 2'd2,
    MODE_MULTICOLOR = 2'd3
  } screen_mode_e;

endpackage

//--- src/ppi_slot.sv
`timescale 1ns/1ns

module ppi_slot (
  input  logic              cpuClock,
  input  logic              n_hard_reset,
  input  logic              i_port_a_wr,
  input  logic              i_port_c_wr,
  input  logic              i_ctrl_wr,
  input  logic [7:0]        i_data,
  input  logic [1:0]        i_page,
  input  logic              i_mem_wr,
  output logic [7:0]        o_port_a,
  output logic [7:0]        o_port_c,
  output logic              o_ram_we,
  output msx_pkg::mem_src_e o_mem_src
);
  import msx_pkg::*;

  logic [1:0] page_slot;
  logic       rom_page;

  // ============================================================
  // PPI registers
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      o_port_a <= 8'h00;
      o_port_c <= 8'h00;
    end else begin
      if (i_port_a_wr) begin
        o_port_a <= i_data;   // Primary slot register
      end
      if (i_port_c_wr) begin
        o_port_c <= i_data;
      end
      // A word with bit 7 set is a mode word and is ignored
      if (i_ctrl_wr && !i_data[7]) begin
        o_port_c[i_data[3:1]] <= i_data[0];
      end
    end
  end

  // ============================================================
  // Slot decode
  // ============================================================

  // Two bits per page with page 0 in bits 1:0
  assign page_slot = o_port_a[{i_page, 1'b0} +: 2];

  // Cartridge answers in pages 1 and 2 only
  assign rom_page = (i_page == 2'd1) || (i_page == 2'd2);

  always_comb begin
    if (page_slot == 2'(ROM_SLOT) && rom_page) begin
      o_mem_src = MEM_ROM;
    end else if (page_slot == 2'(RAM_SLOT)) begin
      o_mem_src = MEM_RAM;
    end else begin
      o_mem_src = MEM_NONE;
    end
  end

  assign o_ram_we = i_mem_wr && (o_mem_src == MEM_RAM);

endmodule

//--- src/vdp_port.sv
`timescale 1ns/1ns

module vdp_port (
  input  logic                          cpuClock,
  input  logic                          n_hard_reset,
  input  logic                          i_clk_edge,
  input  logic                          i_data_wr,
  input  logic                          i_ctrl_wr,
  input  logic                          i_data_rd,
  input  logic                          i_ctrl_rd,
  input  logic [7:0]                    i_data,
  input  logic                          i_interrupt_flag,
  input  logic                          i_sprite_collision,
  output logic [msx_pkg::VRAM_ADDR_W-1:0] o_vram_addr,
  output logic                          o_vram_wr,
  output logic                          o_vram_rd,
  output logic [7:0]                    o_status,
  output msx_pkg::screen_mode_e         o_screen_mode,
  output logic                          o_n_int
);
  import msx_pkg::*;

  logic [7:0] vdp_reg [VDP_REG_COUNT];
  logic       second_byte;   // Next control byte is the second one
  logic [7:0] first_byte;
  logic       data_rd_d;     // Data read seen at the previous edge
  logic       status_rd_d;
  logic       int_flag;
  logic       coll_flag;

  // ============================================================
  // Control port and VRAM address
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      o_vram_addr <= '0;
      second_byte <= 1'b0;
      first_byte  <= 8'h00;
      data_rd_d   <= 1'b0;
      for (int i = 0; i < VDP_REG_COUNT; i++) begin
        vdp_reg[i] <= 8'h00;
      end
    end else begin
      if (i_data_wr) begin
        o_vram_addr <= o_vram_addr + 1'b1;
      end
      // Read data is taken before the address moves on
      if (i_clk_edge) begin
        data_rd_d <= i_data_rd;
        if (data_rd_d && !i_data_rd) begin
          o_vram_addr <= o_vram_addr + 1'b1;
        end
      end
      if (i_ctrl_wr) begin
        second_byte <= !second_byte;
        if (!second_byte) begin
          first_byte <= i_data;
        end else if (!i_data[7]) begin
          o_vram_addr <= {i_data[5:0], first_byte};   // Address setup
        end else if (i_data[5:0] < VDP_REG_COUNT) begin
          vdp_reg[i_data[VDP_REG_IDX_W-1:0]] <= first_byte;
        end
      end
    end
  end

  assign o_vram_wr = i_data_wr;
  assign o_vram_rd = i_data_rd && i_clk_edge;

  // ============================================================
  // Status flags
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      int_flag    <= 1'b0;
      coll_flag   <= 1'b0;
      status_rd_d <= 1'b0;
    end else begin
      if (i_interrupt_flag) begin
        int_flag <= 1'b1;
      end
      if (i_sprite_collision) begin
        coll_flag <= 1'b1;
      end
      if (i_clk_edge) begin
        status_rd_d <= i_ctrl_rd;
        // Clear beats a set in the same cycle
        if (status_rd_d && !i_ctrl_rd) begin
          int_flag  <= 1'b0;
          coll_flag <= 1'b0;
        end
      end
    end
  end

  assign o_status = {int_flag, 1'b1, coll_flag, 5'b11111};

  assign o_n_int = !(int_flag && vdp_reg[1][5]);   // R1 bit 5 is IE

  // M3 is R0 bit 1, M1 R1 bit 4, M2 R1 bit 3
  always_comb begin
    if (vdp_reg[1][3]) begin
      o_screen_mode = MODE_MULTICOLOR;
    end else if (vdp_reg[0][1]) begin
      o_screen_mode = MODE_GRAPHIC2;
    end else if (vdp_reg[1][4]) begin
      o_screen_mode = MODE_TEXT;
    end else begin
      o_screen_mode = MODE_GRAPHIC1;
    end
  end

endmodule

//--- testbench/msx_bus_assert.sv
`timescale 1ns/1ns

module msx_bus_assert (
  input logic       cpuClock,
  input logic       n_hard_reset,
  input logic       i_clk_en,
  input logic       i_n_int,
  input logic [7:0] i_wr_strobes,   // All qualified write strobes plus o_vram_rd
  output int        o_fail_count
);

  logic [3:0] since_rise;   // Cycles since the last o_clk_en rise
  logic       seen_rise;
  logic       clk_en_d;

  initial o_fail_count = 0;

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      since_rise <= 4'd0;
      seen_rise  <= 1'b0;
      clk_en_d   <= 1'b0;
    end else begin
      clk_en_d <= i_clk_en;
      if (i_clk_en && !clk_en_d) begin
        since_rise <= 4'd0;
        seen_rise  <= 1'b1;
      end else if (since_rise != 4'hF) begin
        since_rise <= since_rise + 4'd1;
      end
    end
  end

  // ============================================================
  // Properties
  // ============================================================
  clk_en_period: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    (i_clk_en && !clk_en_d && seen_rise) |-> since_rise == 4'd6)
    else begin
      $error("o_clk_en rises are not 7 cycles apart");
      o_fail_count++;
    end

  clk_en_alive: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    seen_rise |-> since_rise < 4'd7)
    else begin
      $error("o_clk_en stopped rising");
      o_fail_count++;
    end

  strobe_single: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    (|i_wr_strobes) |=> !(|i_wr_strobes))
    else begin
      $error("a write strobe stayed high for more than one cycle");
      o_fail_count++;
    end

  n_int_reset: assert property (@(posedge cpuClock) !n_hard_reset |=> i_n_int)
    else begin
      $error("o_n_int is low right after reset");
      o_fail_count++;
    end

endmodule

//--- testbench/tb_msx_bus.sv
`timescale 1ns/1ns

module tb_msx_bus;
  import msx_pkg::*;

  localparam int HOLD_CYCLES = 7;    // Each access spans one CPU clock edge
  localparam int WAIT_LIMIT  = 50;
  localparam int SRC_RAM     = 0;
  localparam int SRC_ROM     = 1;
  localparam int SRC_NONE    = 2;

  logic                   cpuClock;
  logic                   n_hard_reset;
  logic                   i_n_wr;
  logic                   i_n_rd;
  logic                   i_n_iorq;
  logic                   i_n_mreq;
  logic [15:0]            i_addr;
  logic [7:0]             i_cpu_dout;
  logic [7:0]             i_vram_data;
  logic                   i_interrupt_flag;
  logic                   i_sprite_collision;
  logic [7:0]             i_ram_data;
  logic [7:0]             i_rom_data;
  logic [7:0]             i_port_b;
  logic [7:0]             i_psg_data;
  logic [5:0]             i_btn;
  logic [7:0]             o_cpu_data;
  logic                   o_clk_en;
  logic                   o_n_int;
  logic                   o_vram_wr;
  logic                   o_vram_rd;
  logic                   o_ram_we;
  logic                   o_psg_wr;
  logic [VRAM_ADDR_W-1:0] o_vram_addr;
  screen_mode_e           o_screen_mode;
  logic [3:0]             o_psg_addr;
  logic [3:0]             o_key_row;
  logic                   o_click;

  // Reference model state
  logic [7:0]             m_port_a;
  logic [7:0]             m_port_c;
  logic [3:0]             m_psg_sel;
  logic [7:0]             m_reg [8];
  logic [VRAM_ADDR_W-1:0] m_vram_addr;
  logic                   m_second;
  logic [7:0]             m_first;
  logic                   m_int;
  logic                   m_coll;

  // Snapshot handed to the comparing process
  event        check_ev;
  logic        chk_read;
  logic [7:0]  got_data;
  logic [7:0]  exp_data;
  int          got_cnt [4];
  int          exp_cnt [4];
  logic [15:0] got_out [6];
  logic [15:0] exp_out [6];
  string strobe_name [4] = '{"o_vram_wr cycles", "o_vram_rd cycles", "o_psg_wr cycles",
                             "o_ram_we cycles"};
  string out_name [6] = '{"o_vram_addr", "o_screen_mode", "o_psg_addr", "o_key_row",
                          "o_click", "o_n_int"};

  msx_bus_top msx_bus_top_i (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_n_wr             (i_n_wr),
    .i_n_rd             (i_n_rd),
    .i_n_iorq           (i_n_iorq),
    .i_n_mreq           (i_n_mreq),
    .i_addr             (i_addr),
    .i_cpu_dout         (i_cpu_dout),
    .i_vram_data        (i_vram_data),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_ram_data         (i_ram_data),
    .i_rom_data         (i_rom_data),
    .i_port_b           (i_port_b),
    .i_psg_data         (i_psg_data),
    .i_btn              (i_btn),
    .o_cpu_data         (o_cpu_data),
    .o_clk_en           (o_clk_en),
    .o_n_int            (o_n_int),
    .o_vram_wr          (o_vram_wr),
    .o_vram_rd          (o_vram_rd),
    .o_ram_we           (o_ram_we),
    .o_psg_wr           (o_psg_wr),
    .o_vram_addr        (o_vram_addr),
    .o_screen_mode      (o_screen_mode),
    .o_psg_addr         (o_psg_addr),
    .o_key_row          (o_key_row),
    .o_click            (o_click)
  );

  bind msx_bus_top msx_bus_assert msx_bus_assert_i (
    .cpuClock     (cpuClock),
    .n_hard_reset (n_hard_reset),
    .i_clk_en     (o_clk_en),
    .i_n_int      (o_n_int),
    .i_wr_strobes ({vdp_data_wr, vdp_ctrl_wr, psg_addr_wr, o_psg_wr,
                    ppi_a_wr, ppi_c_wr, ppi_ctrl_wr, o_vram_rd}),
    .o_fail_count ()
  );

  always #5 cpuClock = ~cpuClock;

  task automatic next_cycle();
    @(posedge cpuClock);
    #1;
  endtask

  task automatic report_failure(input string what);
    $display("error: %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("mismatch %s: got %h, expected %h", name, got, exp);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // ============================================================
  // Reference model
  // ============================================================
  function automatic int page_source(input logic [1:0] page);
    logic [1:0] slot;
    case (page)
      2'd0:    slot = m_port_a[1:0];
      2'd1:    slot = m_port_a[3:2];
      2'd2:    slot = m_port_a[5:4];
      default: slot = m_port_a[7:6];
    endcase
    if (slot == 2'd1 && (page == 2'd1 || page == 2'd2)) return SRC_ROM;
    if (slot == 2'd0) return SRC_RAM;
    return SRC_NONE;
  endfunction

  function automatic logic [7:0] expect_read(input logic is_io, input logic [15:0] addr);
    if (!is_io) begin
      case (page_source(addr[15:14]))
        SRC_RAM: return i_ram_data;
        SRC_ROM: return i_rom_data;
        default: return 8'h00;
      endcase
    end
    case (addr[7:0])
      8'h98:   return i_vram_data;
      8'h99:   return {m_int, 1'b1, m_coll, 5'b11111};
      8'hA2:   return (m_psg_sel == 4'd14) ? {2'b00, ~i_btn} : i_psg_data;
      8'hA8:   return m_port_a;
      8'hA9:   return i_port_b;
      8'hAA:   return m_port_c;
      default: return 8'hFF;   // Nothing answers
    endcase
  endfunction

  function automatic logic [1:0] expect_mode();
    if (m_reg[1][3]) return MODE_MULTICOLOR;
    if (m_reg[0][1]) return MODE_GRAPHIC2;
    if (m_reg[1][4]) return MODE_TEXT;
    return MODE_GRAPHIC1;
  endfunction

  task automatic update_model(input logic is_io, input logic is_wr,
                              input logic [15:0] addr, input logic [7:0] data);
    if (!is_io) return;
    if (!is_wr) begin
      if (addr[7:0] == 8'h98) m_vram_addr = m_vram_addr + 14'd1;
      if (addr[7:0] == 8'h99) begin
        m_int  = 1'b0;   // Status read clears both flags
        m_coll = 1'b0;
      end
      return;
    end
    case (addr[7:0])
      8'h98: m_vram_addr = m_vram_addr + 14'd1;
      8'h99: begin
        if (!m_second) begin
          m_first = data;
        end else if (!data[7]) begin
          m_vram_addr = {data[5:0], m_first};
        end else if (data[5:0] < 6'd8) begin
          m_reg[data[2:0]] = m_first;
        end
        m_second = !m_second;
      end
      8'hA0: m_psg_sel = data[3:0];
      8'hA8: m_port_a = data;
      8'hAA: m_port_c = data;
      8'hAB: if (!data[7]) m_port_c[data[3:1]] = data[0];
      default: ;
    endcase
  endtask

  // ============================================================
  // Bus accesses
  // ============================================================
  task automatic bus_access(input logic is_io, input logic is_wr,
                            input logic [15:0] addr, input logic [7:0] data);
    logic [7:0] want_data;
    logic [7:0] rd_data;
    int         cnt [4];
    int         want_cnt [4];
    want_data   = expect_read(is_io, addr);
    want_cnt[0] = (is_io && is_wr && addr[7:0] == 8'h98) ? 1 : 0;
    want_cnt[1] = (is_io && !is_wr && addr[7:0] == 8'h98) ? 1 : 0;
    want_cnt[2] = (is_io && is_wr && addr[7:0] == 8'hA1) ? 1 : 0;
    want_cnt[3] = (!is_io && is_wr && page_source(addr[15:14]) == SRC_RAM) ? HOLD_CYCLES : 0;
    cnt      = '{default: 0};
    rd_data  = 8'h00;
    i_addr     = addr;
    i_cpu_dout = data;
    i_n_iorq   = !is_io;
    i_n_mreq   = is_io;
    i_n_wr     = !is_wr;
    i_n_rd     = is_wr;
    for (int c = 0; c < 2 * HOLD_CYCLES; c++) begin
      if (c == HOLD_CYCLES) begin   // Bus goes idle
        i_n_iorq = 1'b1;
        i_n_mreq = 1'b1;
        i_n_wr   = 1'b1;
        i_n_rd   = 1'b1;
      end
      @(negedge cpuClock);
      cnt[0] += int'(o_vram_wr);
      cnt[1] += int'(o_vram_rd);
      cnt[2] += int'(o_psg_wr);
      cnt[3] += int'(o_ram_we);
      if (c == HOLD_CYCLES - 1) rd_data = o_cpu_data;
      next_cycle();
    end
    update_model(is_io, is_wr, addr, data);
    chk_read   = !is_wr;
    got_data   = rd_data;
    exp_data   = want_data;
    got_cnt    = cnt;
    exp_cnt    = want_cnt;
    got_out[0] = 16'(o_vram_addr);
    got_out[1] = 16'(o_screen_mode);
    got_out[2] = 16'(o_psg_addr);
    got_out[3] = 16'(o_key_row);
    got_out[4] = 16'(o_click);
    got_out[5] = 16'(o_n_int);
    exp_out[0] = 16'(m_vram_addr);
    exp_out[1] = 16'(expect_mode());
    exp_out[2] = 16'(m_psg_sel);
    exp_out[3] = 16'(m_port_c[3:0]);
    exp_out[4] = 16'(m_port_c[7]);
    exp_out[5] = 16'(!(m_int && m_reg[1][5]));
    ->check_ev;
  endtask

  task automatic io_write(input logic [7:0] port, input logic [7:0] data);
    bus_access(1'b1, 1'b1, {8'h00, port}, data);
  endtask

  task automatic io_read(input logic [7:0] port);
    bus_access(1'b1, 1'b0, {8'h00, port}, 8'h00);
  endtask

  task automatic vdp_reg_write(input logic [5:0] idx, input logic [7:0] value);
    io_write(8'h99, value);
    io_write(8'h99, {2'b10, idx});
  endtask

  task automatic pulse_video(input logic irq, input logic coll);
    i_interrupt_flag   = irq;
    i_sprite_collision = coll;
    next_cycle();
    i_interrupt_flag   = 1'b0;
    i_sprite_collision = 1'b0;
    m_int  = m_int | irq;
    m_coll = m_coll | coll;
  endtask

  task automatic wait_n_int(input logic level);
    int n;
    n = 0;
    while (o_n_int !== level && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    assert (o_n_int === level)
      else report_failure("timeout waiting for o_n_int to reach its new level");
  endtask

  // Comparing process
  always @(check_ev) begin
    if (chk_read) begin
      assert (got_data === exp_data)
        else report_mismatch("o_cpu_data", 16'(got_data), 16'(exp_data));
    end
    for (int k = 0; k < 4; k++) begin
      assert (got_cnt[k] == exp_cnt[k])
        else report_mismatch(strobe_name[k], 16'(got_cnt[k]), 16'(exp_cnt[k]));
    end
    for (int k = 0; k < 6; k++) begin
      assert (got_out[k] === exp_out[k])
        else report_mismatch(out_name[k], got_out[k], exp_out[k]);
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================
  initial begin
    logic [7:0]  d;
    logic [13:0] va;
    logic [15:0] ma;
    cpuClock           = 1'b0;
    n_hard_reset       = 1'b0;
    i_n_wr             = 1'b1;
    i_n_rd             = 1'b1;
    i_n_iorq           = 1'b1;
    i_n_mreq           = 1'b1;
    i_addr             = 16'h0000;
    i_cpu_dout         = 8'h00;
    i_vram_data        = 8'h00;
    i_interrupt_flag   = 1'b0;
    i_sprite_collision = 1'b0;
    i_ram_data         = 8'h00;
    i_rom_data         = 8'h00;
    i_port_b           = 8'h00;
    i_psg_data         = 8'h00;
    i_btn              = 6'h3F;   // No button pressed
    m_port_a    = 8'h00;
    m_port_c    = 8'h00;
    m_psg_sel   = 4'h0;
    m_reg       = '{default: 8'h00};
    m_vram_addr = '0;
    m_second    = 1'b0;
    m_first     = 8'h00;
    m_int       = 1'b0;
    m_coll      = 1'b0;
    void'($urandom(32'hafa2_ebfd));
    repeat (2) @(posedge cpuClock);
    #1;
    n_hard_reset = 1'b1;
    assert (o_n_int === 1'b1 && o_vram_addr === '0)
      else report_failure("outputs are not at their reset values");

    // PPI ports and bit set/reset
    repeat (6) begin
      io_write(8'hA8, 8'($urandom));
      io_read(8'hA8);
      io_write(8'hAA, 8'($urandom));
      io_read(8'hAA);
      i_port_b = 8'($urandom);
      io_read(8'hA9);
    end
    repeat (12) begin
      d = {4'b0000, 4'($urandom)};
      io_write(8'hAB, d);
      io_read(8'hAA);
    end
    // Taken as bit set/reset this word would flip port C bit 7
    d = {1'b1, 3'b000, 3'd7, ~m_port_c[7]};
    io_write(8'hAB, d);   // Mode word leaves port C alone
    io_read(8'hAA);

    // Slot select over all pages
    for (int i = 0; i < 6; i++) begin
      d = (i == 0) ? 8'hE4 : (i == 1) ? 8'h50 : 8'($urandom);
      io_write(8'hA8, d);
      for (int p = 0; p < 4; p++) begin
        ma         = {2'(p), 14'($urandom)};
        i_ram_data = 8'($urandom);
        i_rom_data = 8'($urandom);
        bus_access(1'b0, 1'b0, ma, 8'h00);
        bus_access(1'b0, 1'b1, ma, 8'($urandom));
      end
    end

    // VRAM address setup and auto-increment
    va = 14'($urandom);
    io_write(8'h99, va[7:0]);
    io_write(8'h99, {1'b0, 1'($urandom), va[13:8]});
    repeat (4) io_write(8'h98, 8'($urandom));
    repeat (4) begin
      i_vram_data = 8'($urandom);
      io_read(8'h98);
    end

    // Registers and screen mode
    repeat (8) begin
      vdp_reg_write(6'd0, 8'($urandom));
      vdp_reg_write(6'd1, 8'($urandom));
    end
    vdp_reg_write(6'd8, ~m_reg[0]);
    vdp_reg_write(6'd9, ~m_reg[1]);

    // Status flags and interrupt
    vdp_reg_write(6'd1, 8'h20);
    pulse_video(1'b1, 1'b1);
    wait_n_int(1'b0);
    io_read(8'h99);
    wait_n_int(1'b1);
    io_read(8'h99);

    // PSG select, write strobe and joystick
    io_write(8'hA0, 8'h0E);
    i_btn = 6'($urandom);
    io_read(8'hA2);
    io_write(8'hA1, 8'($urandom));
    io_write(8'hA0, {4'($urandom), 4'($urandom % 14)});
    i_psg_data = 8'($urandom);
    io_read(8'hA2);
    io_read(8'h10);
    io_read(8'hA1);

    next_cycle();
    if (msx_bus_top_i.msx_bus_assert_i.o_fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
